//--- fir_types_pkg.sv
// Filter sizes are fixed here; the history and coefficient depth must stay a power of two.
`default_nettype none

package fir_types_pkg;

    // Sample and coefficient widths
    localparam int data_width = 15;
    localparam int tap_width  = 16;

    // History and coefficient memory depth, addressed modulo max_taps
    localparam int max_taps  = 128;
    localparam int idx_width = 7;

    // One bit wider than the index so that a full 128-tap count fits
    localparam int count_width = 8;

    // Room for max_taps full-scale products without overflow
    localparam int acc_width = data_width + tap_width + idx_width;

    // Coefficients are Q1.15
    localparam int frac_bits = 15;

    typedef logic signed [data_width-1:0] sample_t;
    typedef logic signed [tap_width-1:0]  coef_t;
    typedef logic signed [acc_width-1:0]  acc_t;
    typedef logic        [idx_width-1:0]  idx_t;
    typedef logic        [count_width-1:0] count_t;

endpackage

`default_nettype wire

//--- fir_regs_pkg.sv
// Write-only register map; addresses are byte offsets and there is no read-back.
`default_nettype none

package fir_regs_pkg;

    // Configuration port widths
    localparam int cfg_addr_width = 4;
    localparam int cfg_data_width = 16;

    // Tap count, clamped by the filter to 1..max_taps
    localparam logic [cfg_addr_width-1:0] reg_n_taps = 4'h0;

    // Coefficient held until an index write commits it
    localparam logic [cfg_addr_width-1:0] reg_tap_data = 4'h4;

    // Writing an index stores the staged coefficient there
    localparam logic [cfg_addr_width-1:0] reg_tap_index = 4'h8;

endpackage

`default_nettype wire

//--- sync_ram.sv
// Contents power up undefined; a read of the address being written returns the old word.
`timescale 1ns/10ps
`default_nettype none

module sync_ram #(
    parameter type word_t = logic,
    parameter int  depth  = fir_types_pkg::max_taps
) (
    input  logic                clk,
    input  logic                we,
    input  fir_types_pkg::idx_t waddr,
    input  word_t               wdata,
    input  fir_types_pkg::idx_t raddr,
    output word_t               rdata
);

    word_t mem [depth];

    // One write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, one cycle of latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- fir_config_regs.sv
// Tap count writes made while busy are held until the run ends; the last such write wins.
`timescale 1ns/10ps
`default_nettype none

module fir_config_regs (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    cfg_write,
    input  logic [fir_regs_pkg::cfg_addr_width-1:0] cfg_addr,
    input  logic [fir_regs_pkg::cfg_data_width-1:0] cfg_wdata,
    input  logic                                    busy,
    output fir_types_pkg::count_t                   n_taps,
    output logic                                    history_clear,
    output logic                                    coef_we,
    output fir_types_pkg::idx_t                     coef_waddr,
    output fir_types_pkg::coef_t                    coef_wdata
);

    import fir_types_pkg::*;
    import fir_regs_pkg::*;

    logic   wr_taps;
    logic   wr_data;
    logic   wr_index;
    count_t clamped;
    count_t pend_taps;
    logic   pend_valid;
    coef_t  staged;

    // Address decode
    assign wr_taps  = cfg_write && (cfg_addr == reg_n_taps);
    assign wr_data  = cfg_write && (cfg_addr == reg_tap_data);
    assign wr_index = cfg_write && (cfg_addr == reg_tap_index);

    // Keep the tap count inside 1..max_taps
    always_comb begin
        if (cfg_wdata == '0) begin
            clamped = count_t'(1);
        end else if (cfg_wdata > max_taps) begin
            clamped = count_t'(max_taps);
        end else begin
            clamped = cfg_wdata[count_width-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            n_taps        <= count_t'(1);
            pend_taps     <= '0;
            pend_valid    <= 1'b0;
            history_clear <= 1'b0;
            coef_we       <= 1'b0;
        end else begin
            history_clear <= 1'b0;
            coef_we       <= wr_index;
            if (wr_taps && busy) begin
                // A run is in flight, park the new count
                pend_taps  <= clamped;
                pend_valid <= 1'b1;
            end else if (wr_taps) begin
                n_taps        <= clamped;
                pend_valid    <= 1'b0;
                history_clear <= 1'b1;
            end else if (pend_valid && !busy) begin
                n_taps        <= pend_taps;
                pend_valid    <= 1'b0;
                history_clear <= 1'b1;
            end
        end
    end

    // Staged coefficient and the memory write it feeds
    always_ff @(posedge clk) begin
        if (wr_data) begin
            staged <= coef_t'(cfg_wdata);
        end
        if (wr_index) begin
            coef_waddr <= cfg_wdata[idx_width-1:0];
            coef_wdata <= staged;
        end
    end

endmodule

`default_nettype wire

//--- fir_sequencer.sv
// One sample in flight; in_valid while busy is dropped, and busy lasts n_taps + 4 cycles.
`timescale 1ns/10ps
`default_nettype none

module fir_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  fir_types_pkg::sample_t in_data,
    input  fir_types_pkg::count_t  n_taps,
    input  logic                   history_clear,
    output logic                   busy,
    output logic                   hist_we,
    output fir_types_pkg::idx_t    hist_waddr,
    output fir_types_pkg::sample_t hist_wdata,
    output fir_types_pkg::idx_t    hist_raddr,
    output fir_types_pkg::idx_t    coef_raddr,
    output logic                   mac_start,
    output logic                   mac_en,
    output logic                   mac_zero,
    output logic                   mac_last
);

    import fir_types_pkg::*;

    logic   accept;
    idx_t   head;
    count_t fill;
    count_t fill_base;
    count_t fill_next;
    count_t run_taps;
    count_t run_fill;
    count_t busy_cnt;
    logic   walk;
    count_t tap_k;
    logic   rd_en;
    logic   rd_first;
    logic   rd_last;
    logic   rd_zero;

    assign accept = in_valid && !busy;

    // Fill count after taking this sample, saturating at the history depth
    assign fill_base = history_clear ? '0 : fill;
    assign fill_next = (fill_base == count_t'(max_taps)) ? fill_base : fill_base + 1'b1;

    // New sample goes in at the head, written on the edge after acceptance
    assign hist_waddr = head;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
            head     <= '0;
            fill     <= '0;
            run_taps <= count_t'(1);
            run_fill <= '0;
            hist_we  <= 1'b0;
        end else begin
            hist_we <= accept;
            if (accept) begin
                busy     <= 1'b1;
                busy_cnt <= n_taps + count_t'(3);
                head     <= head + 1'b1;
                fill     <= fill_next;
                // Frozen for the whole run
                run_taps <= n_taps;
                run_fill <= fill_next;
            end else begin
                if (history_clear) begin
                    fill <= '0;
                end
                if (busy) begin
                    if (busy_cnt == '0) begin
                        busy <= 1'b0;
                    end else begin
                        busy_cnt <= busy_cnt - 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hist_wdata <= in_data;
        end
    end

    // Tap walk, one address pair per cycle starting the edge after acceptance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            walk      <= 1'b0;
            tap_k     <= '0;
            rd_en     <= 1'b0;
            rd_first  <= 1'b0;
            rd_last   <= 1'b0;
            rd_zero   <= 1'b0;
            mac_en    <= 1'b0;
            mac_start <= 1'b0;
            mac_last  <= 1'b0;
            mac_zero  <= 1'b0;
        end else begin
            rd_en <= walk;
            if (accept) begin
                walk  <= 1'b1;
                tap_k <= '0;
            end else if (walk) begin
                rd_first <= (tap_k == '0);
                rd_last  <= (tap_k == run_taps - 1'b1);
                // Older than anything written since the last clear
                rd_zero  <= (tap_k >= run_fill);
                tap_k    <= tap_k + 1'b1;
                if (tap_k == run_taps - 1'b1) begin
                    walk <= 1'b0;
                end
            end
            // Memory latency stage, lines up with rdata
            mac_en    <= rd_en;
            mac_start <= rd_en && rd_first;
            mac_last  <= rd_en && rd_last;
            mac_zero  <= rd_zero;
        end
    end

    // History index wraps modulo max_taps
    always_ff @(posedge clk) begin
        if (walk) begin
            coef_raddr <= tap_k[idx_width-1:0];
            hist_raddr <= head - tap_k[idx_width-1:0];
        end
    end

endmodule

`default_nettype wire

//--- fir_mac.sv
// Rounds half up after the Q15 shift and clips to the sample range; no output stall.
`timescale 1ns/10ps
`default_nettype none

module fir_mac (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fir_types_pkg::coef_t   coef,
    input  fir_types_pkg::sample_t sample,
    input  logic                   mac_start,
    input  logic                   mac_en,
    input  logic                   mac_zero,
    input  logic                   mac_last,
    output logic                   out_valid,
    output fir_types_pkg::sample_t out_data
);

    import fir_types_pkg::*;

    acc_t    prod;
    logic    prod_valid;
    logic    prod_first;
    logic    prod_last;
    acc_t    acc;
    logic    acc_done;
    acc_t    rounded;
    logic    fits;
    sample_t clipped;

    // Round and clip the finished sum
    always_comb begin
        rounded = (acc + (acc_t'(1) <<< (frac_bits - 1))) >>> frac_bits;
        fits    = (&rounded[acc_width-1:data_width-1]) || !(|rounded[acc_width-1:data_width-1]);
        if (fits) begin
            clipped = rounded[data_width-1:0];
        end else begin
            clipped = {rounded[acc_width-1], {(data_width-1){~rounded[acc_width-1]}}};
        end
    end

    // Product register, full precision
    always_ff @(posedge clk) begin
        if (mac_en) begin
            if (mac_zero) begin
                prod <= '0;
            end else begin
                prod <= coef * sample;
            end
        end
        if (prod_valid) begin
            acc <= prod_first ? prod : acc + prod;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            prod_first <= 1'b0;
            prod_last  <= 1'b0;
            acc_done   <= 1'b0;
            out_valid  <= 1'b0;
            out_data   <= '0;
        end else begin
            prod_valid <= mac_en;
            prod_first <= mac_start;
            prod_last  <= mac_last;
            acc_done   <= prod_valid && prod_last;
            out_valid  <= acc_done;
            if (acc_done) begin
                out_data <= clipped;
            end
        end
    end

endmodule

`default_nettype wire

//--- fir_filter.sv
// Serial FIR, one sample per n_taps + 4 cycles; no back-pressure on out_valid.
`timescale 1ns/10ps
`default_nettype none

module fir_filter (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    cfg_write,
    input  logic [fir_regs_pkg::cfg_addr_width-1:0] cfg_addr,
    input  logic [fir_regs_pkg::cfg_data_width-1:0] cfg_wdata,
    input  logic                                    in_valid,
    input  fir_types_pkg::sample_t                  in_data,
    output logic                                    busy,
    output logic                                    out_valid,
    output fir_types_pkg::sample_t                  out_data
);

    import fir_types_pkg::*;

    count_t  n_taps;
    logic    history_clear;
    logic    coef_we;
    idx_t    coef_waddr;
    coef_t   coef_wdata;
    idx_t    coef_raddr;
    coef_t   coef_rdata;
    logic    hist_we;
    idx_t    hist_waddr;
    sample_t hist_wdata;
    idx_t    hist_raddr;
    sample_t hist_rdata;
    logic    mac_start;
    logic    mac_en;
    logic    mac_zero;
    logic    mac_last;

    fir_config_regs u_config_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_write     (cfg_write),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .busy          (busy),
        .n_taps        (n_taps),
        .history_clear (history_clear),
        .coef_we       (coef_we),
        .coef_waddr    (coef_waddr),
        .coef_wdata    (coef_wdata)
    );

    sync_ram #(.word_t(coef_t), .depth(max_taps)) coef_mem (
        .clk   (clk),
        .we    (coef_we),
        .waddr (coef_waddr),
        .wdata (coef_wdata),
        .raddr (coef_raddr),
        .rdata (coef_rdata)
    );

    // Circular sample history
    sync_ram #(.word_t(sample_t), .depth(max_taps)) hist_mem (
        .clk   (clk),
        .we    (hist_we),
        .waddr (hist_waddr),
        .wdata (hist_wdata),
        .raddr (hist_raddr),
        .rdata (hist_rdata)
    );

    fir_sequencer u_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .n_taps        (n_taps),
        .history_clear (history_clear),
        .busy          (busy),
        .hist_we       (hist_we),
        .hist_waddr    (hist_waddr),
        .hist_wdata    (hist_wdata),
        .hist_raddr    (hist_raddr),
        .coef_raddr    (coef_raddr),
        .mac_start     (mac_start),
        .mac_en        (mac_en),
        .mac_zero      (mac_zero),
        .mac_last      (mac_last)
    );

    fir_mac u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .coef      (coef_rdata),
        .sample    (hist_rdata),
        .mac_start (mac_start),
        .mac_en    (mac_en),
        .mac_zero  (mac_zero),
        .mac_last  (mac_last),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

//--- fir_filter_tb.sv
// Runs one sample at a time; expects a Q15 coefficient format and the fixed 15-bit sample range.
`timescale 1ns/10ps
`default_nettype none

module fir_filter_tb;

    import fir_types_pkg::*;
    import fir_regs_pkg::*;

    // Samples and configuration writes per test, for the run limit
    localparam int samples_total = 24 + 160 + 60 + 20 + 12;
    localparam int cfg_total     = (2 * 21 + 1) + (2 * 101 + 1) + (2 * 37 + 1) + 1;
    localparam int cycle_limit   = 2 * (samples_total * (max_taps + 8) + cfg_total * 2);

    logic                      clk;
    logic                      rst_n;
    logic                      cfg_write;
    logic [cfg_addr_width-1:0] cfg_addr;
    logic [cfg_data_width-1:0] cfg_wdata;
    logic                      in_valid;
    sample_t                   in_data;
    logic                      busy;
    logic                      out_valid;
    sample_t                   out_data;

    // Reference model state, newest sample at index 0
    int coef_tab [max_taps];
    int hist_tab [max_taps];
    int n_cur;
    int err_count;
    int pass_count;
    int fail_count;
    int cycles;

    fir_filter uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run went past %0d clock cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, expected, $time);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int start_errs);
        if (err_count == start_errs) begin
            pass_count++;
            $display("%s finished, no mismatches", name);
        end else begin
            fail_count++;
            $display("%s finished, %0d mismatches", name, err_count - start_errs);
        end
    endtask

    task automatic model_clear();
        for (int i = 0; i < max_taps; i++) begin
            hist_tab[i] = 0;
        end
    endtask

    task automatic model_push(input sample_t s);
        for (int i = max_taps - 1; i > 0; i--) begin
            hist_tab[i] = hist_tab[i-1];
        end
        hist_tab[0] = int'(s);
    endtask

    // Full sum, add half an LSB, arithmetic shift, clip to the sample range
    function automatic sample_t model_output(input int n);
        longint sum;
        sum = 0;
        for (int k = 0; k < n; k++) begin
            sum += longint'(coef_tab[k]) * longint'(hist_tab[k]);
        end
        sum = (sum + (longint'(1) <<< (frac_bits - 1))) >>> frac_bits;
        if (sum > (2 ** (data_width - 1)) - 1) begin
            sum = (2 ** (data_width - 1)) - 1;
        end else if (sum < -(2 ** (data_width - 1))) begin
            sum = -(2 ** (data_width - 1));
        end
        return sample_t'(sum);
    endfunction

    task automatic cfg_reg_write(input logic [cfg_addr_width-1:0] addr,
                                 input logic [cfg_data_width-1:0] data);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cfg_write = 1'b0;
    endtask

    task automatic load_taps(input int n);
        for (int k = 0; k < n; k++) begin
            cfg_reg_write(reg_tap_data, cfg_data_width'(coef_tab[k]));
            cfg_reg_write(reg_tap_index, cfg_data_width'(k));
        end
    endtask

    task automatic set_taps(input int n);
        cfg_reg_write(reg_n_taps, cfg_data_width'(n));
        n_cur = n;
        model_clear();
    endtask

    // Optionally offers a second pulse while busy, which must be dropped
    task automatic push_sample(input sample_t s, input bit offer_extra);
        int      lat;
        sample_t expected;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_data  = s;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        model_push(s);
        expected = model_output(n_cur);
        lat = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
            if (offer_extra && lat == 1) begin
                check("busy", busy, 1'b1);
                in_valid = 1'b1;
                in_data  = ~s;
            end else begin
                in_valid = 1'b0;
            end
        end while (!out_valid && lat <= max_taps + 8);
        if (!out_valid) begin
            $display("No out_valid pulse within %0d cycles of an accepted sample", lat);
            err_count++;
        end else begin
            check("out_data", unsigned'(out_data), unsigned'(expected));
            check("out_valid latency", lat, n_cur + 4);
            @(posedge clk);
            #1;
            check("out_valid", out_valid, 1'b0);
        end
    endtask

    task automatic test_idle();
        int start_errs;
        start_errs = err_count;
        repeat (10) begin
            @(posedge clk);
            #1;
            check("busy", busy, 1'b0);
            check("out_valid", out_valid, 1'b0);
        end
        report_test("idle_after_reset", start_errs);
    endtask

    // 16384 wraps to the most negative sample, so the outputs are the negated halves
    task automatic test_impulse();
        int start_errs;
        start_errs = err_count;
        for (int k = 0; k < 21; k++) begin
            coef_tab[k] = ((k * 2731 + 517) % 20001) - 10000;
        end
        load_taps(21);
        set_taps(21);
        for (int i = 0; i < 24; i++) begin
            push_sample((i == 0) ? sample_t'(16384) : sample_t'(0), 1'b0);
        end
        report_test("impulse_response", start_errs);
    endtask

    // Hamming windowed sinc with gain above one so the square wave clips
    task automatic test_step_saturation();
        int  start_errs;
        real h;
        real w;
        real pi;
        start_errs = err_count;
        pi = 3.14159265358979;
        for (int k = 0; k < 101; k++) begin
            if (k == 50) begin
                h = 0.1;
            end else begin
                h = $sin(2.0 * pi * 0.05 * (k - 50)) / (pi * (k - 50));
            end
            w = 0.54 - 0.46 * $cos(2.0 * pi * k / 100.0);
            coef_tab[k] = $rtoi(h * w * 1.15 * 32768.0);
        end
        load_taps(101);
        set_taps(101);
        for (int i = 0; i < 160; i++) begin
            push_sample(((i / 64) % 2 == 0) ? sample_t'('h37ff) : -sample_t'('h37ff), 1'b0);
        end
        report_test("step_and_saturation", start_errs);
    endtask

    task automatic test_random();
        int start_errs;
        start_errs = err_count;
        for (int k = 0; k < 37; k++) begin
            coef_tab[k] = int'(coef_t'($urandom)) >>> 3;
        end
        load_taps(37);
        set_taps(37);
        for (int i = 0; i < 60; i++) begin
            push_sample(sample_t'($urandom), 1'b0);
        end
        report_test("random_37_taps", start_errs);
    endtask

    task automatic test_history_clear();
        int start_errs;
        start_errs = err_count;
        set_taps(8);
        for (int i = 0; i < 20; i++) begin
            push_sample(sample_t'($urandom), 1'b0);
        end
        report_test("history_clear", start_errs);
    endtask

    task automatic test_busy_drop();
        int start_errs;
        start_errs = err_count;
        for (int i = 0; i < 12; i++) begin
            push_sample(sample_t'($urandom), 1'b1);
        end
        report_test("input_while_busy", start_errs);
    endtask

    initial begin
        void'($urandom(98));
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        cycles     = 0;
        n_cur      = 1;
        rst_n      = 1'b0;
        cfg_write  = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        in_valid   = 1'b0;
        in_data    = '0;
        model_clear();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_idle();
        test_impulse();
        test_step_saturation();
        test_random();
        test_history_clear();
        test_busy_drop();
        $display("Summary: %0d tests clean, %0d tests with mismatches", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fir_filter.f
fir_types_pkg.sv
fir_regs_pkg.sv
sync_ram.sv
fir_config_regs.sv
fir_sequencer.sv
fir_mac.sv
fir_filter.sv
fir_filter_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the FIR testbench with Verilator, runs it, and checks the log for the pass line.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal \
    --top-module fir_filter_tb \
    -f fir_filter.f \
    -o fir_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/fir_sim > sim.log 2>&1 \
    || { echo "Simulator exited with an error, see sim.log"; exit 1; }

grep -q "^TEST PASSED$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
